/* ann_accel.f */
+incdir+include
verilog/ann_types_pkg.sv
verilog/ann_bus_pkg.sv
verilog/ann_controller.sv
verilog/input_node_timer.sv
verilog/node.sv
verilog/ann_activation_buffer.sv
verilog/ann_apb_regs.sv
verilog/ann_top.sv
verification/ann_tb.sv

/* include/ann_defines.svh */
// Network sizes, datapath widths and the APB register map
`ifndef ANN_DEFINES_SVH
`define ANN_DEFINES_SVH

// Network shape
// Node count equals input count for feedback
`define ANN_INPUTS      8
`define ANN_NODES       8
`define ANN_LAYERS      2
`define ANN_FRAC_BITS   8

// Datapath widths
`define ANN_SAMPLE_W    16
`define ANN_ACC_W       36
`define ANN_IDX_W       3
`define ANN_LAYER_W     1

// APB widths
`define ANN_APB_AW      12
`define ANN_APB_DW      32

// Word registers with entry k at base + 4*k
// Weight entry k = (layer * ANN_NODES + node) * ANN_INPUTS + input
`define ANN_ADDR_CTRL       12'h000
`define ANN_ADDR_STATUS     12'h004
`define ANN_ADDR_RESULT     12'h008
`define ANN_ADDR_IMAGE      12'h100
`define ANN_ADDR_WEIGHT     12'h200
`define ANN_ADDR_NODE_OUT   12'h400

`endif

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ann_tb -f ann_accel.f \
	--Mdir obj_dir -o ann_sim \
	&& ./obj_dir/ann_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "All checks passed" sim.log && exit 0 || exit 1

/* verification/ann_tb.sv */
// Testbench of the accelerator top level
// Table of images and weight patterns with a Q8.8 reference model
// APB access tasks, result checks and a cycle limit
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module ann_tb
	import ann_types_pkg::*;
	import ann_bus_pkg::*;
;

	localparam int N_TESTS  = 6;
	localparam int W_TOTAL  = `ANN_LAYERS * `ANN_NODES * `ANN_INPUTS;
	localparam int LATENCY  = 1 + `ANN_LAYERS * (`ANN_INPUTS + 2);
	// Setup, access and idle cycle per transfer
	localparam int XFER     = 3;
	localparam int PER_TEST = 2 * (`ANN_INPUTS + W_TOTAL) + 4 + LATENCY + `ANN_NODES + 1;
	localparam int CYCLE_LIMIT = 2 + XFER * (2 + N_TESTS * PER_TEST) + 100;
	// Weight entry hit by the refused write during an inference
	localparam int BUSY_IDX = 9;

	logic     clk;
	logic     n_rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	int     img_tab [N_TESTS][`ANN_INPUTS];
	int     wgt_tab [N_TESTS][W_TOTAL];
	int     exp_out [N_TESTS][`ANN_NODES];
	int     exp_cls [N_TESTS];
	string  test_name [N_TESTS] = '{"identity", "scaled", "negative", "saturating",
		"random_a", "random_b"};
	integer seed = 32'h7ec8be77;
	int     errors = 0;
	int     passed = 0;
	int     cycles = 0;
	int     errs_before;
	logic [`ANN_APB_DW-1:0] rdata;
	logic   err;

	ann_top dut_i (
		.clk(clk),
		.n_rst(n_rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string what, input int got, input int exp);
		errors++;
		$display("error at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic apb_xfer(input logic wr, input logic [`ANN_APB_AW-1:0] addr,
		input logic [`ANN_APB_DW-1:0] wdata, output logic [`ANN_APB_DW-1:0] rd,
		output logic slverr);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		// Response is settled mid access cycle
		@(negedge clk);
		rd = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		if (!apb_rsp.pready)
			report_problem("PREADY was low in an access cycle");
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic write_reg(input logic [`ANN_APB_AW-1:0] addr, input int data,
		output logic slverr);
		logic [`ANN_APB_DW-1:0] unused;
		apb_xfer(1'b1, addr, 32'(data), unused, slverr);
	endtask

	task automatic read_reg(input logic [`ANN_APB_AW-1:0] addr,
		output logic [`ANN_APB_DW-1:0] rd);
		logic slverr;
		apb_xfer(1'b0, addr, '0, rd, slverr);
		if (slverr)
			report_problem("A read got an error response");
	endtask

	// Image and weights of one table entry
	task automatic fill_entry(input int t);
		int n;
		int i;
		for (int k = 0; k < `ANN_INPUTS; k++) begin
			case (t)
				0: img_tab[t][k] = ((k * 3) % 8 + 1) * 64;
				1: img_tab[t][k] = (k % 3) * 256;
				2: img_tab[t][k] = (k + 1) * 256;
				3: img_tab[t][k] = 32512;
				default: img_tab[t][k] = $random(seed) % 2048;
			endcase
		end
		for (int k = 0; k < W_TOTAL; k++) begin
			n = (k / `ANN_INPUTS) % `ANN_NODES;
			i = k % `ANN_INPUTS;
			case (t)
				0: wgt_tab[t][k] = (n == i) ? 256 : 0;
				1: wgt_tab[t][k] = (n != i) ? 0 : (k < W_TOTAL / 2) ? 512 : 128;
				2: begin
					if (k < W_TOTAL / 2)
						wgt_tab[t][k] = (n != i) ? 0 : (n % 2) ? -256 : 256;
					else
						wgt_tab[t][k] = (n == i) ? 256 : -32;
				end
				3: begin
					if (k < W_TOTAL / 2)
						wgt_tab[t][k] = 32512;
					else
						wgt_tab[t][k] = (n < 4) ? 32767 : -32768;
				end
				default: wgt_tab[t][k] = $random(seed) % 512;
			endcase
		end
	endtask

	// Q8.8 model with shift, saturation to 16 bits and ReLU
	task automatic build_expected(input int t);
		int     x [`ANN_INPUTS];
		int     y [`ANN_NODES];
		longint acc;
		int     best;
		for (int i = 0; i < `ANN_INPUTS; i++)
			x[i] = img_tab[t][i];
		for (int l = 0; l < `ANN_LAYERS; l++) begin
			for (int n = 0; n < `ANN_NODES; n++) begin
				acc = 0;
				for (int i = 0; i < `ANN_INPUTS; i++)
					acc += longint'(x[i]) *
						longint'(wgt_tab[t][(l * `ANN_NODES + n) * `ANN_INPUTS + i]);
				acc = acc >>> `ANN_FRAC_BITS;
				if (acc > 32767)
					acc = 32767;
				else if (acc < -32768)
					acc = -32768;
				y[n] = (acc < 0) ? 0 : int'(acc);
			end
			for (int i = 0; i < `ANN_INPUTS; i++)
				x[i] = y[i];
		end
		best = 0;
		for (int i = 0; i < `ANN_NODES; i++) begin
			exp_out[t][i] = x[i];
			if (x[i] > x[best])
				best = i;
		end
		exp_cls[t] = best;
	endtask

	task automatic wait_done();
		rdata = '0;
		while (!rdata[1])
			read_reg(`ANN_ADDR_STATUS, rdata);
	endtask

	initial begin
		n_rst = 1'b0;
		apb_req = '0;
		for (int t = 0; t < N_TESTS; t++) begin
			fill_entry(t);
			build_expected(t);
		end
		repeat (2) @(posedge clk);
		n_rst <= 1'b1;

		// Idle state after reset
		read_reg(`ANN_ADDR_STATUS, rdata);
		if (rdata !== 32'h0)
			report_mismatch("STATUS after reset", int'(rdata), 0);
		read_reg(`ANN_ADDR_RESULT, rdata);
		if (rdata !== 32'h0)
			report_mismatch("RESULT after reset", int'(rdata), 0);
		$display("test reset: %0d errors", errors);

		for (int t = 0; t < N_TESTS; t++) begin
			errs_before = errors;
			for (int i = 0; i < `ANN_INPUTS; i++) begin
				write_reg(`ANN_ADDR_IMAGE + 12'(4 * i), img_tab[t][i], err);
				if (err)
					report_problem($sformatf("Image write %0d was refused", i));
			end
			for (int k = 0; k < W_TOTAL; k++) begin
				write_reg(`ANN_ADDR_WEIGHT + 12'(4 * k), wgt_tab[t][k], err);
				if (err)
					report_problem($sformatf("Weight write %0d was refused", k));
			end
			for (int i = 0; i < `ANN_INPUTS; i++) begin
				read_reg(`ANN_ADDR_IMAGE + 12'(4 * i), rdata);
				if (rdata !== 32'(img_tab[t][i]))
					report_mismatch($sformatf("image %0d", i), int'(rdata), img_tab[t][i]);
			end
			for (int k = 0; k < W_TOTAL; k++) begin
				read_reg(`ANN_ADDR_WEIGHT + 12'(4 * k), rdata);
				if (rdata !== 32'(wgt_tab[t][k]))
					report_mismatch($sformatf("weight %0d", k), int'(rdata), wgt_tab[t][k]);
			end

			write_reg(`ANN_ADDR_CTRL, 1, err);
			if (err)
				report_problem("Start write was refused while idle");
			// Both writes land while the inference is running
			write_reg(`ANN_ADDR_WEIGHT + 12'(4 * BUSY_IDX), 16'h1234, err);
			if (!err)
				report_problem("Weight write during an inference was not refused");
			write_reg(`ANN_ADDR_CTRL, 1, err);
			if (!err)
				report_problem("Start write during an inference was not refused");

			wait_done();
			if (rdata !== 32'h2)
				report_mismatch("STATUS at done", int'(rdata), 2);
			read_reg(`ANN_ADDR_RESULT, rdata);
			if (rdata !== 32'(exp_cls[t]))
				report_mismatch("RESULT", int'(rdata), exp_cls[t]);
			for (int n = 0; n < `ANN_NODES; n++) begin
				read_reg(`ANN_ADDR_NODE_OUT + 12'(4 * n), rdata);
				if (rdata !== 32'(exp_out[t][n]))
					report_mismatch($sformatf("node output %0d", n), int'(rdata),
						exp_out[t][n]);
			end
			read_reg(`ANN_ADDR_WEIGHT + 12'(4 * BUSY_IDX), rdata);
			if (rdata !== 32'(wgt_tab[t][BUSY_IDX]))
				report_mismatch("weight after refused write", int'(rdata),
					wgt_tab[t][BUSY_IDX]);

			if (errors == errs_before)
				passed++;
			$display("test %0d %s: %0d errors", t, test_name[t], errors - errs_before);
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			N_TESTS, passed, N_TESTS - passed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/ann_activation_buffer.sv */
// Layer input register shared by all nodes
// Loads the image or the node outputs, gives the argmax of its contents
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module ann_activation_buffer
	import ann_types_pkg::*;
(
	input  wire            clk,
	input  wire            n_rst,
	input  wire load_sel_t load_sel,
	input  wire act_vec_t  image,
	input  wire act_vec_t  node_out,
	output act_vec_t       data_in,
	output idx_t           class_idx
);

	sample_t best;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			data_in <= '0;
		else begin
			case (load_sel)
				LOAD_IMAGE: data_in <= image;
				LOAD_NODES: data_in <= node_out;
				default:    data_in <= data_in;
			endcase
		end
	end

	// Strict compare keeps the lowest index on ties
	always_comb begin
		best      = data_in[0];
		class_idx = '0;
		for (int i = 1; i < `ANN_INPUTS; i++) begin
			if (data_in[i] > best) begin
				best      = data_in[i];
				class_idx = idx_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/ann_apb_regs.sv */
// APB slave of the accelerator
// Image and weight storage, start control, status and result reads
// Per-node coefficient selection for the current layer and input
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module ann_apb_regs
	import ann_types_pkg::*;
	import ann_bus_pkg::*;
(
	input  wire            clk,
	input  wire            n_rst,
	input  wire  apb_req_t apb_req,
	output apb_rsp_t       apb_rsp,
	input  wire            busy,
	input  wire            done,
	input  wire  layer_t   layer,
	input  wire  idx_t     input_num,
	input  wire  act_vec_t node_out,
	input  wire  idx_t     class_idx,
	output logic           start,
	output act_vec_t       image,
	output coef_vec_t      coef
);

	localparam int W_TOTAL = `ANN_LAYERS * `ANN_NODES * `ANN_INPUTS;
	localparam int W_IDX_W = $clog2(W_TOTAL);

	sample_t weights [W_TOTAL];

	logic                   access;
	logic                   wr_access;
	logic                   ctrl_hit;
	logic                   status_hit;
	logic                   result_hit;
	logic                   img_hit;
	logic                   wgt_hit;
	logic                   out_hit;
	logic                   wr_blocked;
	logic [`ANN_APB_AW-1:0] img_off;
	logic [`ANN_APB_AW-1:0] wgt_off;
	logic [`ANN_APB_AW-1:0] out_off;
	idx_t                   img_idx;
	idx_t                   out_idx;
	logic [W_IDX_W-1:0]     wgt_idx;
	logic [`ANN_APB_DW-1:0] rd_data;

	function automatic logic [`ANN_APB_DW-1:0] sext(sample_t s);
		return {{(`ANN_APB_DW - `ANN_SAMPLE_W){s[`ANN_SAMPLE_W-1]}}, s};
	endfunction

	// Access phase completes in the same cycle
	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;

	// Address decode
	assign img_off = apb_req.paddr - `ANN_ADDR_IMAGE;
	assign wgt_off = apb_req.paddr - `ANN_ADDR_WEIGHT;
	assign out_off = apb_req.paddr - `ANN_ADDR_NODE_OUT;

	assign ctrl_hit   = apb_req.paddr == `ANN_ADDR_CTRL;
	assign status_hit = apb_req.paddr == `ANN_ADDR_STATUS;
	assign result_hit = apb_req.paddr == `ANN_ADDR_RESULT;
	assign img_hit = (apb_req.paddr >= `ANN_ADDR_IMAGE) && (img_off < 4 * `ANN_INPUTS);
	assign wgt_hit = (apb_req.paddr >= `ANN_ADDR_WEIGHT) && (wgt_off < 4 * W_TOTAL);
	assign out_hit = (apb_req.paddr >= `ANN_ADDR_NODE_OUT) && (out_off < 4 * `ANN_NODES);

	assign img_idx = img_off[2 +: `ANN_IDX_W];
	assign wgt_idx = wgt_off[2 +: W_IDX_W];
	assign out_idx = out_off[2 +: `ANN_IDX_W];

	// Control and storage writes are refused during an inference
	assign wr_blocked = busy && (ctrl_hit || img_hit || wgt_hit);

	assign start = wr_access && ctrl_hit && apb_req.pwdata[0] && !busy;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			image <= '0;
			for (int k = 0; k < W_TOTAL; k++)
				weights[k] <= '0;
		end else if (wr_access && !busy) begin
			if (img_hit)
				image[img_idx] <= apb_req.pwdata[`ANN_SAMPLE_W-1:0];
			if (wgt_hit)
				weights[wgt_idx] <= apb_req.pwdata[`ANN_SAMPLE_W-1:0];
		end
	end

	// One weight per node for the current layer and input
	always_comb begin
		for (int n = 0; n < `ANN_NODES; n++)
			coef[n] = weights[(int'(layer) * `ANN_NODES + n) * `ANN_INPUTS + int'(input_num)];
	end

	// Read mux with sign extended samples
	always_comb begin
		rd_data = '0;
		if (status_hit)
			rd_data = {{(`ANN_APB_DW - 2){1'b0}}, done, busy};
		else if (result_hit)
			rd_data = `ANN_APB_DW'(class_idx);
		else if (img_hit)
			rd_data = sext(image[img_idx]);
		else if (wgt_hit)
			rd_data = sext(weights[wgt_idx]);
		else if (out_hit)
			rd_data = sext(node_out[out_idx]);
	end

	assign apb_rsp = '{pready: 1'b1, pslverr: wr_access && wr_blocked, prdata: rd_data};

	// Status never shows busy and done together
	a_status: assert property (@(posedge clk) disable iff (!n_rst)
		!(busy && done));

	// Controller leaves idle or done right after a start
	a_start_busy: assert property (@(posedge clk) disable iff (!n_rst)
		start |=> busy);

endmodule

`default_nettype wire

/* verilog/ann_bus_pkg.sv */
// APB request and response structs of the host port
`default_nettype none
`include "ann_defines.svh"

package ann_bus_pkg;

	// Host to slave
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`ANN_APB_AW-1:0] paddr;
		logic [`ANN_APB_DW-1:0] pwdata;
	} apb_req_t;

	// Slave to host with pready tied high
	typedef struct packed {
		logic                   pready;
		logic                   pslverr;
		logic [`ANN_APB_DW-1:0] prdata;
	} apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/ann_controller.sv */
// Sequencing FSM of the accelerator
// Image load, then clear, run and store for every layer, then done
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module ann_controller
	import ann_types_pkg::*;
(
	input  wire       clk,
	input  wire       n_rst,
	input  wire       start,
	input  wire       last_input,
	output load_sel_t load_sel,
	output logic      clear_acc,
	output logic      accumulate,
	output logic      timer_go,
	output layer_t    layer,
	output logic      busy,
	output logic      done
);

	ann_state_t state;
	ann_state_t next_state;
	logic       last_layer;

	assign last_layer = layer == layer_t'(`ANN_LAYERS - 1);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			layer <= '0;
		end else begin
			state <= next_state;
			// Next layer after each store and back to 0 after the last
			if (state == STORE)
				layer <= last_layer ? '0 : layer + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:  if (start) next_state = LOAD;
			LOAD:  next_state = CLEAR;
			CLEAR: next_state = RUN;
			RUN:   if (last_input) next_state = STORE;
			STORE: next_state = last_layer ? DONE : CLEAR;
			DONE:  if (start) next_state = LOAD;
			default: next_state = IDLE;
		endcase
	end

	// Moore outputs
	always_comb begin
		case (state)
			LOAD:    load_sel = LOAD_IMAGE;
			STORE:   load_sel = LOAD_NODES;
			default: load_sel = HOLD;
		endcase
	end

	assign clear_acc  = state == CLEAR;
	assign accumulate = state == RUN;
	assign timer_go   = state == RUN;
	assign busy       = state inside {LOAD, CLEAR, RUN, STORE};
	assign done       = state == DONE;

	// Outputs fed back only after the timer has seen the last input
	a_load_nodes: assert property (@(posedge clk) disable iff (!n_rst)
		load_sel == LOAD_NODES |-> state == STORE && $past(last_input));

endmodule

`default_nettype wire

/* verilog/ann_top.sv */
// Accelerator top level
// APB slave, controller, input timer, node bank and activation buffer
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module ann_top
	import ann_types_pkg::*;
	import ann_bus_pkg::*;
(
	input  wire           clk,
	input  wire           n_rst,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp
);

	logic      start;
	logic      busy;
	logic      done;
	logic      clear_acc;
	logic      accumulate;
	logic      timer_go;
	logic      last_input;
	load_sel_t load_sel;
	layer_t    layer;
	idx_t      input_num;
	idx_t      class_idx;
	act_vec_t  image;
	act_vec_t  data_in;
	act_vec_t  node_out;
	coef_vec_t coef;

	ann_apb_regs u_regs (
		.clk(clk),
		.n_rst(n_rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.busy(busy),
		.done(done),
		.layer(layer),
		.input_num(input_num),
		.node_out(node_out),
		.class_idx(class_idx),
		.start(start),
		.image(image),
		.coef(coef)
	);

	ann_controller u_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.last_input(last_input),
		.load_sel(load_sel),
		.clear_acc(clear_acc),
		.accumulate(accumulate),
		.timer_go(timer_go),
		.layer(layer),
		.busy(busy),
		.done(done)
	);

	input_node_timer u_timer (
		.clk(clk),
		.n_rst(n_rst),
		.timer_go(timer_go),
		.input_num(input_num),
		.last_input(last_input)
	);

	ann_activation_buffer u_buf (
		.clk(clk),
		.n_rst(n_rst),
		.load_sel(load_sel),
		.image(image),
		.node_out(node_out),
		.data_in(data_in),
		.class_idx(class_idx)
	);

	// Node bank reused for every layer
	for (genvar n = 0; n < `ANN_NODES; n++) begin : g_node
		node u_node (
			.clk(clk),
			.n_rst(n_rst),
			.clear_acc(clear_acc),
			.accumulate(accumulate),
			.data_in(data_in),
			.input_num(input_num),
			.coef(coef[n]),
			.node_out(node_out[n])
		);
	end

endmodule

`default_nettype wire

/* verilog/ann_types_pkg.sv */
// Datapath types of the accelerator
// Q8.8 samples, activation and coefficient vectors, indices
// Controller states and buffer load selection
`default_nettype none
`include "ann_defines.svh"

package ann_types_pkg;

	// Signed Q8.8 value
	typedef logic signed [`ANN_SAMPLE_W-1:0] sample_t;

	// One sample per input for image, buffer and node outputs
	typedef sample_t [`ANN_INPUTS-1:0] act_vec_t;

	// One weight per node for the current input
	typedef sample_t [`ANN_NODES-1:0] coef_vec_t;

	// Node accumulator wide enough for a full layer of products
	typedef logic signed [`ANN_ACC_W-1:0] acc_t;

	typedef logic [`ANN_IDX_W-1:0] idx_t;
	typedef logic [`ANN_LAYER_W-1:0] layer_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		CLEAR,
		RUN,
		STORE,
		DONE
	} ann_state_t;

	// What the activation buffer takes on the next edge
	typedef enum logic [1:0] {
		HOLD,
		LOAD_IMAGE,
		LOAD_NODES
	} load_sel_t;

endpackage

`default_nettype wire

/* verilog/input_node_timer.sv */
// Input index counter for the accumulate phase
// Flags the last input of a layer
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module input_node_timer
	import ann_types_pkg::*;
(
	input  wire  clk,
	input  wire  n_rst,
	input  wire  timer_go,
	output idx_t input_num,
	output logic last_input
);

	assign last_input = timer_go && (input_num == idx_t'(`ANN_INPUTS - 1));

	// Counts while enabled and parks at 0 otherwise
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			input_num <= '0;
		else if (timer_go && !last_input)
			input_num <= input_num + 1'b1;
		else
			input_num <= '0;
	end

	// Every layer starts from input 0
	a_parked: assert property (@(posedge clk) disable iff (!n_rst)
		!timer_go |-> input_num == '0);

endmodule

`default_nettype wire

/* verilog/node.sv */
// Multiply-accumulate node
// Q8.8 scaling, saturation and ReLU on the final sum
`timescale 1ns/100ps
`default_nettype none
`include "ann_defines.svh"

module node
	import ann_types_pkg::*;
(
	input  wire           clk,
	input  wire           n_rst,
	input  wire           clear_acc,
	input  wire           accumulate,
	input  wire act_vec_t data_in,
	input  wire idx_t     input_num,
	input  wire sample_t  coef,
	output sample_t       node_out
);

	localparam int SAT_MAX = 2 ** (`ANN_SAMPLE_W - 1) - 1;

	logic signed [2*`ANN_SAMPLE_W-1:0] product;
	acc_t                              acc;
	acc_t                              sum;
	acc_t                              scaled;
	sample_t                           activated;

	assign product = $signed(data_in[input_num]) * coef;
	assign sum     = acc + product;
	assign scaled  = sum >>> `ANN_FRAC_BITS;

	// Upper clamp at the Q8.8 maximum
	// Lower clamp and ReLU both end at 0
	always_comb begin
		if (scaled > acc_t'(SAT_MAX))
			activated = sample_t'(SAT_MAX);
		else if (scaled < 0)
			activated = '0;
		else
			activated = scaled[`ANN_SAMPLE_W-1:0];
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			acc      <= '0;
			node_out <= '0;
		end else if (clear_acc) begin
			acc <= '0;
		end else if (accumulate) begin
			acc <= sum;
			// Result taken on the last accumulate edge and held through store
			if (input_num == idx_t'(`ANN_INPUTS - 1))
				node_out <= activated;
		end
	end

endmodule

`default_nettype wire
